// File: design/anim_fsm.sv
`timescale 1ns/1ns

module anim_fsm
(
	input  logic                            frame_clk,
	input  logic                            rst,
	input  logic [knight_pkg::STATUS_W-1:0] player_status,
	input  logic                            step,
	output logic [knight_pkg::STATUS_W-1:0] pose,
	output logic [knight_pkg::FRAME_W-1:0]  frame_base,
	output logic [knight_pkg::FRAME_W-1:0]  frame_ofs,
	output logic                            restart
);
	import knight_pkg::*;

	logic [STATUS_W-1:0] status_in;
	logic [FRAME_W-1:0] frame_cnt;

	// Unknown codes show the idle pose
	assign status_in = (player_status > ST_ATTACK) ? ST_IDLE : player_status;

	always_comb
	begin
		case (pose)
			ST_WALK:
			begin
				frame_base = BASE_WALK;
				frame_cnt = WALK_FRAMES;
			end
			ST_JUMP:
			begin
				frame_base = BASE_JUMP;
				frame_cnt = 'd1;
			end
			ST_FALL:
			begin
				frame_base = BASE_FALL;
				frame_cnt = FALL_FRAMES;
			end
			ST_ATTACK:
			begin
				frame_base = BASE_ATTACK;
				frame_cnt = ATTACK_FRAMES;
			end
			default:
			begin
				frame_base = BASE_IDLE;
				frame_cnt = 'd1;
			end
		endcase
	end

	always_ff @(posedge frame_clk)
	begin
		if (rst)
		begin
			pose <= ST_IDLE;
			frame_ofs <= '0;
			restart <= 1'b0;
		end
		else if (status_in != pose)
		begin
			pose <= status_in; // New pose starts on its first frame
			frame_ofs <= '0;
			restart <= 1'b1;
		end
		else
		begin
			restart <= 1'b0;
			if (step)
				frame_ofs <= (frame_ofs == frame_cnt - 1'b1) ? '0 : frame_ofs + 1'b1;
		end
	end

endmodule

// File: design/frame_timer.sv
`timescale 1ns/1ns

module frame_timer
(
	input  logic                            frame_clk,
	input  logic                            rst,
	input  logic                            frame_start,
	input  logic                            restart,
	input  logic [knight_pkg::STATUS_W-1:0] pose,
	output logic                            step
);
	import knight_pkg::*;

	logic [HOLD_W-1:0] count;
	logic [HOLD_W-1:0] last;

	// Fall frames stay up longer
	assign last = (pose == ST_FALL) ? HOLD_W'(HOLD_LONG - 1) : HOLD_W'(HOLD_SHORT - 1);

	always_ff @(posedge frame_clk)
	begin
		if (rst || restart)
		begin
			count <= '0;
			step <= 1'b0;
		end
		else if (frame_start && count == last)
		begin
			count <= '0;
			step <= 1'b1;
		end
		else
		begin
			if (frame_start)
				count <= count + 1'b1;
			step <= 1'b0;
		end
	end

endmodule

// File: design/knight_mapper.sv
`timescale 1ns/1ns

module knight_mapper
(
	input  logic                            frame_clk,
	input  logic                            rst,
	input  logic [knight_pkg::COORD_W-1:0]  draw_x,
	input  logic [knight_pkg::COORD_W-1:0]  draw_y,
	input  logic [knight_pkg::COORD_W-1:0]  player_x,
	input  logic [knight_pkg::COORD_W-1:0]  player_y,
	input  logic [knight_pkg::COORD_W-1:0]  heart_x,
	input  logic [knight_pkg::COORD_W-1:0]  heart_y,
	input  logic                            blank,
	input  logic                            frame_start,
	input  logic                            inverse,
	input  logic [knight_pkg::STATUS_W-1:0] player_status,
	input  logic [knight_pkg::LIFE_W-1:0]   player_life,
	input  logic                            load_en,
	input  logic [knight_pkg::ADDR_W-1:0]   load_addr,
	input  logic [knight_pkg::PIX_W-1:0]    load_data,
	output logic [7:0]                      red,
	output logic [7:0]                      green,
	output logic [7:0]                      blue
);
	import knight_pkg::*;

	logic [STATUS_W-1:0] pose;
	logic [FRAME_W-1:0] frame_base, frame_ofs;
	logic restart, step;
	logic [ADDR_W-1:0] addr;
	logic knight_hit, heart_hit, vis;
	logic [2:0] heart_slot;
	logic [PIX_W-1:0] pix;

	anim_fsm i_anim_fsm (.frame_clk(frame_clk), .rst(rst), .player_status(player_status),
		.step(step), .pose(pose), .frame_base(frame_base), .frame_ofs(frame_ofs),
		.restart(restart));

	frame_timer i_frame_timer (.frame_clk(frame_clk), .rst(rst), .frame_start(frame_start),
		.restart(restart), .pose(pose), .step(step));

	// Stage 1
	sprite_window i_sprite_window (.frame_clk(frame_clk), .rst(rst), .draw_x(draw_x),
		.draw_y(draw_y), .blank(blank), .player_x(player_x), .player_y(player_y),
		.inverse(inverse), .heart_x(heart_x), .heart_y(heart_y), .frame_base(frame_base),
		.frame_ofs(frame_ofs), .addr(addr), .knight_hit(knight_hit), .heart_hit(heart_hit),
		.heart_slot(heart_slot), .vis(vis));

	// Stage 2
	sprite_rom i_sprite_rom (.frame_clk(frame_clk), .addr(addr), .load_en(load_en),
		.load_addr(load_addr), .load_data(load_data), .pix(pix));

	// Stage 3
	pixel_compositor i_pixel_compositor (.frame_clk(frame_clk), .rst(rst),
		.knight_hit(knight_hit), .heart_hit(heart_hit), .heart_slot(heart_slot), .vis(vis),
		.pix(pix), .player_life(player_life), .red(red), .green(green), .blue(blue));

endmodule

// File: design/knight_pkg.sv
package knight_pkg;

	// Bus widths
	localparam int COORD_W = 10;
	localparam int STATUS_W = 4;
	localparam int LIFE_W = 4;
	localparam int ADDR_W = 16;
	localparam int PIX_W = 3;
	localparam int FRAME_W = 4;

	// Knight frame box, offset up-left of the player position
	localparam int KNIGHT_W = 50;
	localparam int KNIGHT_H = 64;
	localparam int KNIGHT_OFS_X = 24;
	localparam int KNIGHT_OFS_Y = 30;
	localparam int KNIGHT_PIXELS = KNIGHT_W * KNIGHT_H;

	localparam int HEART_W = 12;
	localparam int HEART_H = 16;
	localparam int HEART_PITCH = 16;
	localparam int HEART_COUNT = 5;
	localparam int HEART_BASE = 35200; // Right after the 11 knight frames
	localparam int SPRITE_WORDS = HEART_BASE + HEART_W * HEART_H;

	localparam logic [STATUS_W-1:0] ST_IDLE = 'd0;
	localparam logic [STATUS_W-1:0] ST_WALK = 'd1;
	localparam logic [STATUS_W-1:0] ST_JUMP = 'd2;
	localparam logic [STATUS_W-1:0] ST_FALL = 'd3;
	localparam logic [STATUS_W-1:0] ST_ATTACK = 'd4;

	localparam logic [FRAME_W-1:0] WALK_FRAMES = 'd3;
	localparam logic [FRAME_W-1:0] FALL_FRAMES = 'd2;
	localparam logic [FRAME_W-1:0] ATTACK_FRAMES = 'd4;

	// First frame of each pose in sprite memory
	localparam logic [FRAME_W-1:0] BASE_IDLE = 'd0;
	localparam logic [FRAME_W-1:0] BASE_WALK = 'd1;
	localparam logic [FRAME_W-1:0] BASE_JUMP = 'd4;
	localparam logic [FRAME_W-1:0] BASE_FALL = 'd5;
	localparam logic [FRAME_W-1:0] BASE_ATTACK = 'd7;

	// Video frames per animation frame
	localparam int HOLD_SHORT = 6;
	localparam int HOLD_LONG = 16;
	localparam int HOLD_W = $clog2(HOLD_LONG);

	localparam logic [PIX_W-1:0] TRANSPARENT = 'd0;
	localparam logic [0:7][11:0] KNIGHT_PALETTE = {12'hC9F, 12'hEEE, 12'h222, 12'h445,
		12'h889, 12'hBBC, 12'h735, 12'hFD8};
	localparam logic [0:3][11:0] HEART_PALETTE = {12'hCCC, 12'hF22, 12'hA11, 12'hFFF};
	localparam logic [11:0] BG_COLOR = 12'h135;
	localparam logic [23:0] LOST_HEART = 24'h102030; // Already 8 bits per channel

endpackage

// File: design/pixel_compositor.sv
`timescale 1ns/1ns

module pixel_compositor
(
	input  logic                          frame_clk,
	input  logic                          rst,
	input  logic                          knight_hit,
	input  logic                          heart_hit,
	input  logic [2:0]                    heart_slot,
	input  logic                          vis,
	input  logic [knight_pkg::PIX_W-1:0]  pix,
	input  logic [knight_pkg::LIFE_W-1:0] player_life,
	output logic [7:0]                    red,
	output logic [7:0]                    green,
	output logic [7:0]                    blue
);
	import knight_pkg::*;

	logic knight_d, heart_d, vis_d;
	logic [2:0] slot_d;
	logic [23:0] rgb_next;

	// 4-bit channels go out as the high nibble
	function automatic logic [23:0] expand(input logic [11:0] c);
		return {c[11:8], 4'h0, c[7:4], 4'h0, c[3:0], 4'h0};
	endfunction

	// Line up with pix from the memory
	always_ff @(posedge frame_clk)
	begin
		if (rst)
		begin
			knight_d <= 1'b0;
			heart_d <= 1'b0;
			vis_d <= 1'b0;
		end
		else
		begin
			knight_d <= knight_hit;
			heart_d <= heart_hit;
			vis_d <= vis;
		end
	end

	always_ff @(posedge frame_clk)
	begin
		slot_d <= heart_slot;
	end

	always_comb
	begin
		if (!vis_d)
			rgb_next = '0;
		else if (knight_d && pix != TRANSPARENT)
			rgb_next = expand(KNIGHT_PALETTE[pix]);
		else if (heart_d && pix[1:0] != 2'(TRANSPARENT))
			rgb_next = (player_life > LIFE_W'(slot_d)) ? expand(HEART_PALETTE[pix[1:0]])
				: LOST_HEART;
		else
			rgb_next = expand(BG_COLOR); // Transparent pixels fall through here
	end

	always_ff @(posedge frame_clk)
	begin
		if (rst)
			{red, green, blue} <= '0;
		else
			{red, green, blue} <= rgb_next;
	end

endmodule

// File: design/sprite_rom.sv
`timescale 1ns/1ns

module sprite_rom
(
	input  logic                          frame_clk,
	input  logic [knight_pkg::ADDR_W-1:0] addr,
	input  logic                          load_en,
	input  logic [knight_pkg::ADDR_W-1:0] load_addr,
	input  logic [knight_pkg::PIX_W-1:0]  load_data,
	output logic [knight_pkg::PIX_W-1:0]  pix
);
	import knight_pkg::*;

	// Knight frames first, then the heart image
	logic [PIX_W-1:0] mem [SPRITE_WORDS];

	// Host load port
	always_ff @(posedge frame_clk)
	begin
		if (load_en)
			mem[load_addr] <= load_data;
	end

	always_ff @(posedge frame_clk)
	begin
		pix <= mem[addr];
	end

endmodule

// File: design/sprite_window.sv
`timescale 1ns/1ns

module sprite_window
(
	input  logic                           frame_clk,
	input  logic                           rst,
	input  logic [knight_pkg::COORD_W-1:0] draw_x,
	input  logic [knight_pkg::COORD_W-1:0] draw_y,
	input  logic                           blank,
	input  logic [knight_pkg::COORD_W-1:0] player_x,
	input  logic [knight_pkg::COORD_W-1:0] player_y,
	input  logic                           inverse,
	input  logic [knight_pkg::COORD_W-1:0] heart_x,
	input  logic [knight_pkg::COORD_W-1:0] heart_y,
	input  logic [knight_pkg::FRAME_W-1:0] frame_base,
	input  logic [knight_pkg::FRAME_W-1:0] frame_ofs,
	output logic [knight_pkg::ADDR_W-1:0]  addr,
	output logic                           knight_hit,
	output logic                           heart_hit,
	output logic [2:0]                     heart_slot,
	output logic                           vis
);
	import knight_pkg::*;

	logic signed [COORD_W+1:0] lx, ly, hdx, hdy;
	logic knight_on, heart_on, hy_on;
	logic [5:0] kx;
	logic [3:0] hx;
	logic [2:0] slot;
	logic [FRAME_W-1:0] frame_idx;
	logic [ADDR_W-1:0] knight_addr, heart_addr;

	// Local coordinates, negative when left of or above the box
	assign lx = $signed({2'b00, draw_x}) - $signed({2'b00, player_x})
		+ (COORD_W+2)'(KNIGHT_OFS_X);
	assign ly = $signed({2'b00, draw_y}) - $signed({2'b00, player_y})
		+ (COORD_W+2)'(KNIGHT_OFS_Y);
	assign hdx = $signed({2'b00, draw_x}) - $signed({2'b00, heart_x});
	assign hdy = $signed({2'b00, draw_y}) - $signed({2'b00, heart_y});

	assign knight_on = (lx >= 0) && (lx < KNIGHT_W) && (ly >= 0) && (ly < KNIGHT_H);
	assign kx = inverse ? 6'(KNIGHT_W - 1) - lx[5:0] : lx[5:0]; // Mirror for left facing
	assign frame_idx = frame_base + frame_ofs;
	assign knight_addr = ADDR_W'(frame_idx) * ADDR_W'(KNIGHT_PIXELS)
		+ ADDR_W'(ly[5:0]) * ADDR_W'(KNIGHT_W) + ADDR_W'(kx);

	assign hy_on = (hdy >= 0) && (hdy < HEART_H);

	// Gaps between hearts are not part of any slot
	always_comb
	begin
		heart_on = 1'b0;
		slot = '0;
		hx = '0;
		for (int i = 0; i < HEART_COUNT; i++)
		begin
			if (hdx >= i * HEART_PITCH && hdx < i * HEART_PITCH + HEART_W)
			begin
				heart_on = hy_on;
				slot = 3'(i);
				hx = 4'(hdx - i * HEART_PITCH);
			end
		end
	end

	assign heart_addr = ADDR_W'(HEART_BASE) + ADDR_W'(hdy[3:0]) * ADDR_W'(HEART_W)
		+ ADDR_W'(hx);

	always_ff @(posedge frame_clk)
	begin
		if (rst)
		begin
			knight_hit <= 1'b0;
			heart_hit <= 1'b0;
			vis <= 1'b0;
		end
		else
		begin
			knight_hit <= knight_on;
			heart_hit <= heart_on && !knight_on; // Knight drawn on top
			vis <= blank;
		end
	end

	always_ff @(posedge frame_clk)
	begin
		addr <= knight_on ? knight_addr : heart_addr;
		heart_slot <= slot;
	end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the knight mapper testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_knight_mapper -f vlog.f
./obj_dir/Vtb_knight_mapper | tee sim.log

if grep -q "TEST FAILED" sim.log; then
	echo "Simulation reported a failure"
	exit 1
fi
echo "Simulation finished without failure"

// File: sim/tb_knight_mapper.sv
`timescale 1ns/1ns

module tb_knight_mapper;
	import knight_pkg::*;

	typedef struct packed {
		logic [STATUS_W-1:0] status;
		logic inv;
		logic [LIFE_W-1:0] life;
		logic [7:0] pulses;
		logic [COORD_W-1:0] px;
		logic [COORD_W-1:0] py;
		logic [COORD_W-1:0] probe_x;
		logic [COORD_W-1:0] probe_y;
		logic [FRAME_W-1:0] frame; // Expected frame number
	} row_t;

	localparam int NROWS = 15;
	localparam int BURST = 16;
	localparam int HEART_X = 20;
	localparam int HEART_Y = 10;
	localparam int ROW_CYCLES = 80; // Longest row needs about 60
	localparam int TIMEOUT = 10 + SPRITE_WORDS + NROWS * ROW_CYCLES;

	logic frame_clk, rst, blank, frame_start, inverse, load_en;
	logic [COORD_W-1:0] draw_x, draw_y, player_x, player_y, heart_x, heart_y;
	logic [STATUS_W-1:0] player_status;
	logic [LIFE_W-1:0] player_life;
	logic [ADDR_W-1:0] load_addr;
	logic [PIX_W-1:0] load_data;
	logic [7:0] red, green, blue;

	logic [PIX_W-1:0] image [SPRITE_WORDS]; // Copy of the sprite memory
	logic [31:0] lfsr;
	row_t rows [NROWS];
	int cycles = 0;

	knight_mapper i_dut (.frame_clk(frame_clk), .rst(rst), .draw_x(draw_x), .draw_y(draw_y),
		.player_x(player_x), .player_y(player_y), .heart_x(heart_x), .heart_y(heart_y),
		.blank(blank), .frame_start(frame_start), .inverse(inverse),
		.player_status(player_status), .player_life(player_life), .load_en(load_en),
		.load_addr(load_addr), .load_data(load_data), .red(red), .green(green), .blue(blue));

	initial
	begin
		frame_clk = 1'b0;
		forever #4 frame_clk = ~frame_clk;
	end

	always @(posedge frame_clk)
	begin
		cycles++;
		if (cycles > TIMEOUT)
		begin
			$display("Timeout: run did not finish within %0d cycles", TIMEOUT);
			$display("TEST FAILED");
			$fatal(1, "simulation timed out");
		end
	end

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [23:0] widen_color(input logic [11:0] c);
		return {c[11:8], 4'h0, c[7:4], 4'h0, c[3:0], 4'h0};
	endfunction

	function automatic logic [23:0] model_rgb(input logic [COORD_W-1:0] x, y, input logic b,
		input row_t r);
		int lx, ly, hdx, hdy, slot, off;
		logic [PIX_W-1:0] p;
		if (!b)
			return 24'h0;
		lx = int'(x) - int'(r.px) + KNIGHT_OFS_X;
		ly = int'(y) - int'(r.py) + KNIGHT_OFS_Y;
		if (lx >= 0 && lx < KNIGHT_W && ly >= 0 && ly < KNIGHT_H)
		begin
			if (r.inv)
				lx = KNIGHT_W - 1 - lx;
			p = image[int'(r.frame) * KNIGHT_PIXELS + ly * KNIGHT_W + lx];
			return (p != TRANSPARENT) ? widen_color(KNIGHT_PALETTE[p]) : widen_color(BG_COLOR);
		end
		hdx = int'(x) - HEART_X;
		hdy = int'(y) - HEART_Y;
		slot = hdx / HEART_PITCH;
		off = hdx % HEART_PITCH;
		if (hdx >= 0 && hdy >= 0 && hdy < HEART_H && slot < HEART_COUNT && off < HEART_W)
		begin
			p = image[HEART_BASE + hdy * HEART_W + off];
			if (p[1:0] != 2'b00)
				return (int'(r.life) > slot) ? widen_color(HEART_PALETTE[p[1:0]]) : LOST_HEART;
		end
		return widen_color(BG_COLOR);
	endfunction

	task automatic check_rgb(input logic [7:0] r, g, b, er, eg, eb,
		input logic [COORD_W-1:0] x, y);
		logic bad;
		bad = 1'b0;
		if (r !== er)
		begin
			$display("ERR red: 0x%h, expected 0x%h (x %0d, y %0d)", r, er, x, y);
			bad = 1'b1;
		end
		if (!bad && g !== eg)
		begin
			$display("ERR green: 0x%h, expected 0x%h (x %0d, y %0d)", g, eg, x, y);
			bad = 1'b1;
		end
		if (!bad && b !== eb)
		begin
			$display("ERR blue: 0x%h, expected 0x%h (x %0d, y %0d)", b, eb, x, y);
			bad = 1'b1;
		end
		if (bad)
		begin
			$display("TEST FAILED");
			$fatal(1, "pixel colour mismatch");
		end
	endtask

	task automatic load_sprites();
		logic [PIX_W-1:0] d;
		for (int a = 0; a < SPRITE_WORDS; a++)
		begin
			for (int i = 0; i < PIX_W; i++)
			begin
				lfsr = lfsr_next(lfsr);
				d[i] = lfsr[0];
			end
			if (a == HEART_BASE + 2 * HEART_W + 1)
				d = TRANSPARENT; // Slot 0 probe hits a see-through heart pixel
			image[a] = d;
			@(posedge frame_clk);
			load_en <= 1'b1;
			load_addr <= ADDR_W'(a);
			load_data <= d;
		end
		@(posedge frame_clk);
		load_en <= 1'b0;
	endtask

	// Probes go in one per cycle and are checked three edges later
	task automatic probe_burst(input row_t r);
		logic [COORD_W-1:0] bx [BURST];
		logic [COORD_W-1:0] by [BURST];
		logic bb [BURST];
		logic [23:0] e;
		for (int k = 0; k < 8; k++)
		begin
			bx[k] = r.probe_x + COORD_W'(7 * k);
			by[k] = r.probe_y + COORD_W'(8 * k);
			bb[k] = 1'b1;
		end
		bx[8] = r.probe_x + COORD_W'(21);
		by[8] = r.probe_y + COORD_W'(24);
		bb[8] = 1'b0; // Blanked probe on the knight
		for (int i = 0; i < HEART_COUNT; i++)
		begin
			bx[9 + i] = COORD_W'(HEART_X + 18 * i + 1);
			by[9 + i] = COORD_W'(HEART_Y + 3 * i + 2);
			bb[9 + i] = 1'b1;
		end
		bx[14] = COORD_W'(HEART_X + HEART_PITCH + 13); // Gap after slot 1
		by[14] = COORD_W'(HEART_Y + 5);
		bb[14] = 1'b1;
		bx[15] = COORD_W'(900);
		by[15] = COORD_W'(700);
		bb[15] = 1'b1;
		for (int c = 0; c < BURST + 3; c++)
		begin
			@(posedge frame_clk);
			if (c < BURST)
			begin
				draw_x <= bx[c];
				draw_y <= by[c];
				blank <= bb[c];
			end
			@(negedge frame_clk);
			if (c >= 3)
			begin
				e = model_rgb(bx[c - 3], by[c - 3], bb[c - 3], r);
				check_rgb(red, green, blue, e[23:16], e[15:8], e[7:0], bx[c - 3], by[c - 3]);
			end
		end
	endtask

	task automatic apply_row(input row_t r);
		@(posedge frame_clk);
		player_status <= r.status;
		inverse <= r.inv;
		player_life <= r.life;
		player_x <= r.px;
		player_y <= r.py;
		repeat (3) @(posedge frame_clk); // Let restart clear the timer
		for (int i = 0; i < int'(r.pulses); i++)
		begin
			@(posedge frame_clk);
			frame_start <= 1'b1;
			@(posedge frame_clk);
			frame_start <= 1'b0;
		end
		repeat (4) @(posedge frame_clk);
		probe_burst(r);
	endtask

	initial
	begin
		rst = 1'b1;
		blank = 1'b0;
		frame_start = 1'b0;
		inverse = 1'b0;
		load_en = 1'b0;
		load_addr = '0;
		load_data = '0;
		draw_x = '0;
		draw_y = '0;
		player_x = '0;
		player_y = '0;
		heart_x = COORD_W'(HEART_X);
		heart_y = COORD_W'(HEART_Y);
		player_status = ST_IDLE;
		player_life = '0;
		lfsr = 32'hd635_341f;

		// status, inverse, life, pulses, player x/y, probe x/y, frame
		rows[0] = '{ST_IDLE, 1'b0, 4'd5, 8'd3, 10'd200, 10'd150, 10'd176, 10'd120, 4'd0};
		rows[1] = '{ST_WALK, 1'b0, 4'd3, 8'd0, 10'd200, 10'd150, 10'd176, 10'd120, 4'd1};
		rows[2] = '{ST_WALK, 1'b1, 4'd3, 8'd6, 10'd200, 10'd150, 10'd176, 10'd120, 4'd2};
		rows[3] = '{ST_WALK, 1'b0, 4'd2, 8'd6, 10'd200, 10'd150, 10'd170, 10'd115, 4'd3};
		rows[4] = '{ST_WALK, 1'b1, 4'd2, 8'd6, 10'd200, 10'd150, 10'd180, 10'd124, 4'd1};
		rows[5] = '{ST_JUMP, 1'b0, 4'd4, 8'd6, 10'd200, 10'd150, 10'd176, 10'd120, 4'd4};
		rows[6] = '{ST_FALL, 1'b1, 4'd1, 8'd15, 10'd200, 10'd150, 10'd176, 10'd120, 4'd5};
		rows[7] = '{ST_FALL, 1'b1, 4'd1, 8'd1, 10'd200, 10'd150, 10'd178, 10'd122, 4'd6};
		rows[8] = '{ST_FALL, 1'b0, 4'd0, 8'd16, 10'd200, 10'd150, 10'd176, 10'd120, 4'd5};
		rows[9] = '{ST_ATTACK, 1'b0, 4'd5, 8'd6, 10'd200, 10'd150, 10'd176, 10'd120, 4'd8};
		rows[10] = '{ST_ATTACK, 1'b1, 4'd7, 8'd12, 10'd200, 10'd150, 10'd176, 10'd120, 4'd10};
		rows[11] = '{ST_ATTACK, 1'b0, 4'd4, 8'd15, 10'd200, 10'd150, 10'd172, 10'd118, 4'd8};
		rows[12] = '{ST_WALK, 1'b1, 4'd3, 8'd5, 10'd200, 10'd150, 10'd176, 10'd120, 4'd1};
		rows[13] = '{ST_IDLE, 1'b0, 4'd2, 8'd0, 10'd60, 10'd40, 10'd36, 10'd10, 4'd0};
		rows[14] = '{4'd9, 1'b1, 4'd5, 8'd2, 10'd60, 10'd40, 10'd40, 10'd12, 4'd0};

		repeat (5) @(posedge frame_clk);
		rst <= 1'b0;
		@(negedge frame_clk);
		check_rgb(red, green, blue, 8'h00, 8'h00, 8'h00, draw_x, draw_y); // Black after reset
		load_sprites();
		for (int n = 0; n < NROWS; n++)
			apply_row(rows[n]);
		$display("TEST OK");
		$finish;
	end

endmodule

// File: vlog.f
design/knight_pkg.sv
design/anim_fsm.sv
design/frame_timer.sv
design/sprite_window.sv
design/sprite_rom.sv
design/pixel_compositor.sv
design/knight_mapper.sv
sim/tb_knight_mapper.sv
